// File: build.f
rtl/sd_pkg.sv
rtl/sd_regs.sv
rtl/sd_sector_buffer.sv
rtl/sd_stream.sv
rtl/sd_link.sv
rtl/sd_host_top.sv
verif/sd_card_model.sv
verif/sd_host_tb.sv

// File: Makefile
# Verilator build and run for the sd sector host

TOP = sd_host_tb

all: run

run:
	verilator --binary --timing --timescale 1ns/1ns --top-module $(TOP) -f build.f -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ns --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

// File: verif/sd_host_tb.sv
// ************************************************
// sd sector host testbench
// wishbone stimulus, random sectors, reference model
// ************************************************
`timescale 1ns/1ns

module sd_host_tb;

    localparam int ACK_LIMIT  = 8;       // cycles to wait for wb_ack
    localparam int POLL_LIMIT = 4000;    // status reads before giving up

    logic             CLK;
    logic             RESET;
    logic             wb_cyc;
    logic             wb_stb;
    logic             wb_we;
    sd_pkg::wb_addr_t wb_adr;
    sd_pkg::wb_data_t wb_dat_w;
    sd_pkg::wb_data_t wb_dat_r;
    logic             wb_ack;
    logic             sd_clk;
    logic             sd_dat_dir;
    wire  [3:0]       sd_dat;
    logic             bad_token;
    logic             silent;
    sd_pkg::sector_t  card_sector;
    int               card_frames;

    sd_pkg::byte_t    ref_mem [longint];   // key is sector * 512 + byte index

    pullup (sd_dat[0]);
    pullup (sd_dat[1]);
    pullup (sd_dat[2]);
    pullup (sd_dat[3]);

    sd_host_top #(
        .CLK_DIV        (2),
        .TIMEOUT_CYCLES (64)
    ) sd_host_top_i (
        .CLK        (CLK),        .RESET      (RESET),
        .wb_cyc     (wb_cyc),     .wb_stb     (wb_stb),
        .wb_we      (wb_we),      .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),   .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),     .sd_clk     (sd_clk),
        .sd_dat     (sd_dat),     .sd_dat_dir (sd_dat_dir)
    );

    sd_card_model card_i (
        .sd_clk    (sd_clk),    .sd_dat (sd_dat),
        .bad_token (bad_token), .silent (silent),
        .sector    (card_sector), .frames (card_frames)
    );

    always #50 CLK = !CLK;   // 100 ns period

    // ************************************************
    // checks
    // ************************************************
    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input sd_pkg::wb_data_t got,
                              input sd_pkg::wb_data_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_byte(input string name, input sd_pkg::byte_t got,
                              input sd_pkg::byte_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_sector(input string name, input sd_pkg::sector_t got,
                                input sd_pkg::sector_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // ************************************************
    // wishbone access and reference model
    // ************************************************
    task automatic bus_cycle(input logic we, input sd_pkg::wb_addr_t adr,
                             input sd_pkg::wb_data_t wdata, output sd_pkg::wb_data_t rdata);
        int   n;
        logic ack;
        n     = 0;
        ack   = 1'b0;
        rdata = '0;
        @(posedge CLK);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        while (!ack && n < ACK_LIMIT) begin
            @(posedge CLK);
            n++;
            ack   = wb_ack;                        // value from the cycle just ended
            rdata = wb_dat_r;
        end
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        if (!ack) begin
            $display("no ack from the register block at word address %h", adr);
            abort_run();
        end
        if (n != 2) begin
            $display("ack at word address %h came after %0d cycles, not 2", adr, n);
            abort_run();
        end
    endtask

    task automatic write_word(input sd_pkg::wb_addr_t adr, input sd_pkg::wb_data_t data);
        sd_pkg::wb_data_t unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic read_word(input sd_pkg::wb_addr_t adr, output sd_pkg::wb_data_t data);
        bus_cycle(1'b0, adr, '0, data);
    endtask

    task automatic start_op(input sd_pkg::sector_t sec, input logic write);
        write_word(sd_pkg::REG_SECTOR, sec);
        write_word(sd_pkg::REG_CTRL, {30'b0, write, 1'b1});
    endtask

    task automatic poll_status(input sd_pkg::wb_data_t mask, output sd_pkg::wb_data_t status);
        int n;
        n = 0;
        read_word(sd_pkg::REG_STATUS, status);
        while ((status & mask) == 0 && n < POLL_LIMIT) begin
            read_word(sd_pkg::REG_STATUS, status);
            n++;
        end
        if ((status & mask) == 0) begin
            $display("status bits %h never came up, last status %h", mask, status);
            abort_run();
        end
    endtask

    function automatic longint mem_key(input sd_pkg::sector_t sec, input int idx);
        return longint'(sec) * sd_pkg::SECTOR_BYTES + idx;
    endfunction

    // buffer word w carries bytes 4w..4w+3, lowest byte in bits 7:0
    function automatic sd_pkg::wb_data_t pack_word(input sd_pkg::sector_t sec, input int w);
        sd_pkg::wb_data_t word;
        for (int k = 0; k < 4; k++)
            word[8*k +: 8] = ref_mem[mem_key(sec, 4*w + k)];
        return word;
    endfunction

    // ************************************************
    // test sequence
    // ************************************************
    initial begin
        sd_pkg::wb_data_t rd;
        sd_pkg::wb_data_t wd;
        sd_pkg::sector_t  sec;
        sd_pkg::byte_t    b;
        int               frames0;
        CLK       = 1'b0;
        RESET     = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        bad_token = 1'b0;
        silent    = 1'b0;
        void'($urandom(32'h1bbdacb7));
        repeat (2) @(posedge CLK);
        RESET <= 1'b0;

        // pins idle after reset
        check_bit("sd_dat_dir", sd_dat_dir, 1'b0);
        check_bit("sd_clk", sd_clk, 1'b0);

        // reset status and sector register readback
        read_word(sd_pkg::REG_STATUS, rd);
        check_word("REG_STATUS", rd, 32'h0);
        repeat (4) begin
            wd = $urandom();
            write_word(sd_pkg::REG_SECTOR, wd);
            read_word(sd_pkg::REG_SECTOR, rd);
            check_word("REG_SECTOR", rd, wd);
        end

        // sector write, card must capture sector number and every byte
        sec = $urandom();
        for (int w = 0; w < 128; w++) begin
            wd = $urandom();
            write_word(sd_pkg::wb_addr_t'(sd_pkg::BUF_BASE + w), wd);
            for (int k = 0; k < 4; k++)
                ref_mem[mem_key(sec, 4*w + k)] = wd[8*k +: 8];
        end
        start_op(sec, 1'b1);
        poll_status(32'h2, rd);
        check_word("REG_STATUS", rd, 32'h2);              // done, no errors
        check_sector("card sector", card_sector, sec);
        for (int i = 0; i < sd_pkg::SECTOR_BYTES; i++)
            check_byte("card data", card_i.data[i], ref_mem[mem_key(sec, i)]);

        // sector read of random card data
        sec = $urandom();
        for (int i = 0; i < sd_pkg::SECTOR_BYTES; i++) begin
            b = 8'($urandom());
            ref_mem[mem_key(sec, i)] = b;
            card_i.data[i] = b;
        end
        start_op(sec, 1'b0);
        poll_status(32'h2, rd);
        check_word("REG_STATUS", rd, 32'h2);
        check_sector("card sector", card_sector, sec);
        for (int w = 0; w < 128; w++) begin
            read_word(sd_pkg::wb_addr_t'(sd_pkg::BUF_BASE + w), rd);
            check_word("buffer word", rd, pack_word(sec, w));
        end

        // write answered with a bad token
        @(posedge CLK);
        bad_token <= 1'b1;
        start_op($urandom(), 1'b1);
        poll_status(32'h2, rd);
        check_word("REG_STATUS", rd, 32'h6);              // done and token error
        @(posedge CLK);
        bad_token <= 1'b0;
        silent    <= 1'b1;

        // silent card, second start while busy must be dropped
        frames0 = card_frames;
        start_op($urandom(), 1'b0);
        read_word(sd_pkg::REG_STATUS, rd);
        check_word("REG_STATUS busy", rd & 32'h1, 32'h1);
        check_bit("sd_dat_dir", sd_dat_dir, 1'b1);        // header still driven by host
        write_word(sd_pkg::REG_CTRL, 32'h1);
        poll_status(32'h2, rd);
        check_word("REG_STATUS", rd, 32'hA);              // done and timeout
        check_word("card frames", sd_pkg::wb_data_t'(card_frames - frames0), 32'h1);
        check_bit("sd_dat_dir", sd_dat_dir, 1'b0);        // bus back with the card
        check_bit("sd_clk", sd_clk, 1'b0);                // parked low when idle

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: verif/sd_card_model.sv
// ************************************************
// behavioral sd card
// decodes data-line frames, keeps the written sector
// and answers reads with its stored bytes
// ************************************************
`timescale 1ns/1ns

module sd_card_model (
    input  logic            sd_clk,
    inout  wire [3:0]       sd_dat,
    input  logic            bad_token,   // answer writes with a wrong token
    input  logic            silent,      // never answer a frame
    output sd_pkg::sector_t sector,      // sector number of the last frame
    output int              frames       // frames seen since power-up
);

    sd_pkg::byte_t   data [sd_pkg::SECTOR_BYTES];  // written bytes, or bytes to send
    sd_pkg::nibble_t dout;
    sd_pkg::nibble_t op_nib;
    sd_pkg::nibble_t hi;
    logic            oe;

    assign sd_dat = oe ? dout : 4'bzzzz;

    // card changes its nibble on the falling edge, like the host
    task automatic drive_on_fall(input sd_pkg::nibble_t nib);
        @(negedge sd_clk);
        oe   = 1'b1;
        dout = nib;
    endtask

    task automatic release_on_fall();
        @(negedge sd_clk);
        oe = 1'b0;
    endtask

    initial begin
        oe     = 1'b0;
        dout   = 4'hF;
        sector = '0;
        frames = 0;
        forever begin
            @(posedge sd_clk);
            if (sd_dat == 4'h0) begin                  // start nibble
                frames = frames + 1;
                @(posedge sd_clk);
                op_nib = sd_dat;
                for (int i = 0; i < 8; i++) begin
                    @(posedge sd_clk);
                    sector = {sector[27:0], sd_dat};   // msb nibble first
                end
                if (op_nib == sd_pkg::OP_WRITE) begin
                    for (int b = 0; b < sd_pkg::SECTOR_BYTES; b++) begin
                        @(posedge sd_clk);
                        hi = sd_dat;
                        @(posedge sd_clk);
                        data[b] = {hi, sd_dat};        // high nibble first
                    end
                    if (!silent) begin
                        @(negedge sd_clk);             // host lets go of the bus
                        drive_on_fall(4'h0);
                        drive_on_fall(bad_token ? 4'hA : sd_pkg::TOKEN_OK);
                        release_on_fall();
                    end
                end else if (!silent) begin
                    @(negedge sd_clk);                 // host lets go of the bus
                    drive_on_fall(4'h0);
                    for (int b = 0; b < sd_pkg::SECTOR_BYTES; b++) begin
                        drive_on_fall(data[b][7:4]);
                        drive_on_fall(data[b][3:0]);
                    end
                    release_on_fall();                 // sd_clk parks low at done
                end
            end
        end
    end

endmodule

// File: rtl/sd_host_top.sv
// ************************************************
// sd sector host top level
// registers, buffer, transfer engine and link
// ************************************************
`timescale 1ns/1ns

module sd_host_top #(
    parameter int CLK_DIV        = 2,
    parameter int TIMEOUT_CYCLES = 64
)(
    input  logic             CLK,
    input  logic             RESET,
    input  logic             wb_cyc,
    input  logic             wb_stb,
    input  logic             wb_we,
    input  sd_pkg::wb_addr_t wb_adr,
    input  sd_pkg::wb_data_t wb_dat_w,
    output sd_pkg::wb_data_t wb_dat_r,
    output logic             wb_ack,
    output logic             sd_clk,
    inout  wire [3:0]        sd_dat,
    output logic             sd_dat_dir
);

    // host side
    sd_pkg::row_addr_t host_row;
    logic [1:0]        host_lane;
    sd_pkg::wb_data_t  host_wdata;
    sd_pkg::wb_data_t  host_rdata;
    logic              host_we;
    logic              start, busy, done, token_err, timed_out;
    sd_pkg::sd_op_t    op;
    sd_pkg::sector_t   sector;
    // engine side
    sd_pkg::row_addr_t eng_row;
    sd_pkg::row_t      eng_wdata;
    sd_pkg::row_t      eng_rdata;
    logic              eng_we;
    // link side
    logic              link_start, link_busy, link_done;
    logic              link_token_err, link_timed_out;
    logic              rx_valid, tx_req;
    sd_pkg::byte_t     rx_byte;
    sd_pkg::byte_t     tx_byte;

    sd_regs regs_i (
        .CLK        (CLK),        .RESET      (RESET),
        .wb_cyc     (wb_cyc),     .wb_stb     (wb_stb),
        .wb_we      (wb_we),      .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),   .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),     .host_row   (host_row),
        .host_lane  (host_lane),  .host_wdata (host_wdata),
        .host_we    (host_we),    .host_rdata (host_rdata),
        .start      (start),      .op         (op),
        .sector     (sector),     .busy       (busy),
        .done       (done),       .token_err  (token_err),
        .timed_out  (timed_out)
    );

    sd_sector_buffer buffer_i (
        .CLK        (CLK),
        .host_row   (host_row),   .host_lane  (host_lane),
        .host_wdata (host_wdata), .host_we    (host_we),
        .host_rdata (host_rdata), .eng_row    (eng_row),
        .eng_wdata  (eng_wdata),  .eng_we     (eng_we),
        .eng_rdata  (eng_rdata)
    );

    sd_stream stream_i (
        .CLK            (CLK),            .RESET          (RESET),
        .start          (start),          .op             (op),
        .sector         (sector),         .busy           (busy),
        .done           (done),           .token_err      (token_err),
        .timed_out      (timed_out),      .eng_row        (eng_row),
        .eng_wdata      (eng_wdata),      .eng_we         (eng_we),
        .eng_rdata      (eng_rdata),      .link_start     (link_start),
        .link_busy      (link_busy),      .link_done      (link_done),
        .link_token_err (link_token_err), .link_timed_out (link_timed_out),
        .rx_valid       (rx_valid),       .rx_byte        (rx_byte),
        .tx_req         (tx_req),         .tx_byte        (tx_byte)
    );

    sd_link #(
        .CLK_DIV        (CLK_DIV),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) link_i (
        .CLK            (CLK),            .RESET          (RESET),
        .link_start     (link_start),     .op             (op),
        .sector         (sector),         .link_busy      (link_busy),
        .link_done      (link_done),      .link_token_err (link_token_err),
        .link_timed_out (link_timed_out), .rx_valid       (rx_valid),
        .rx_byte        (rx_byte),        .tx_req         (tx_req),
        .tx_byte        (tx_byte),        .sd_clk         (sd_clk),
        .sd_dat_dir     (sd_dat_dir),     .sd_dat         (sd_dat)
    );

endmodule

// File: rtl/sd_link.sv
// ************************************************
// sd 4-bit data link
// divided clock, header and data framing, status
// token check and start-nibble timeout
// ************************************************
`timescale 1ns/1ns

module sd_link #(
    parameter int CLK_DIV        = 2,   // CLK cycles per sd_clk half-period
    parameter int TIMEOUT_CYCLES = 64   // sd_clk periods to wait for start nibble
)(
    input  logic            CLK,
    input  logic            RESET,
    input  logic            link_start,
    input  sd_pkg::sd_op_t  op,
    input  sd_pkg::sector_t sector,
    output logic            link_busy,
    output logic            link_done,
    output logic            link_token_err,
    output logic            link_timed_out,
    output logic            rx_valid,
    output sd_pkg::byte_t   rx_byte,
    output logic            tx_req,
    input  sd_pkg::byte_t   tx_byte,
    output logic            sd_clk,
    output logic            sd_dat_dir,
    inout  wire [3:0]       sd_dat
);

    localparam int DIV_W = $clog2(CLK_DIV + 1);
    localparam int TMO_W = $clog2(TIMEOUT_CYCLES + 1);
    localparam int CNT_W = $clog2(sd_pkg::SECTOR_BYTES + 1);

    sd_pkg::link_state_t state;
    logic [DIV_W-1:0]    div_cnt;
    logic [TMO_W-1:0]    tmo_cnt;
    logic [CNT_W-1:0]    cnt;       // header nibbles, then bytes
    logic [35:0]         hdr_sh;    // op nibble + sector
    sd_pkg::nibble_t     dout;
    sd_pkg::nibble_t     nib_q;     // spare nibble of current byte
    sd_pkg::nibble_t     din;
    logic                lo;        // low nibble phase
    logic                run, tick, rise, fall, tx_hi;

    assign din        = sd_dat;
    assign sd_dat     = sd_dat_dir ? dout : 4'bzzzz;
    assign link_busy  = state != sd_pkg::IDLE;
    assign link_done  = state == sd_pkg::DONE;
    assign run        = link_busy && !link_done;
    assign tick       = div_cnt == DIV_W'(CLK_DIV - 1);
    assign rise       = run && tick && !sd_clk;
    assign fall       = run && tick && sd_clk;
    // high nibble of a data byte goes out on this fall
    assign tx_hi = (state == sd_pkg::HEADER && cnt == CNT_W'(9) && op == sd_pkg::OP_WRITE)
                || (state == sd_pkg::TX_DATA && !lo && cnt != CNT_W'(sd_pkg::SECTOR_BYTES));

    // ************************************************
    // clock divider, sd_clk idles low
    // ************************************************
    always_ff @(posedge CLK) begin
        if (RESET || !run) begin
            div_cnt <= '0;
            sd_clk  <= 1'b0;
        end else if (tick) begin
            div_cnt <= '0;
            sd_clk  <= !sd_clk;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ************************************************
    // frame fsm
    // ************************************************
    always_ff @(posedge CLK) begin
        if (RESET) begin
            state          <= sd_pkg::IDLE;
            sd_dat_dir     <= 1'b0;
            tx_req         <= 1'b0;
            rx_valid       <= 1'b0;
            link_token_err <= 1'b0;
            link_timed_out <= 1'b0;
            cnt            <= '0;
            lo             <= 1'b0;
            tmo_cnt        <= '0;
        end else begin
            tx_req   <= 1'b0;
            rx_valid <= 1'b0;
            tmo_cnt  <= (state == sd_pkg::WAIT_START) ? tmo_cnt + TMO_W'(rise) : '0;
            case (state)
                sd_pkg::IDLE: if (link_start) begin
                    state          <= sd_pkg::HEADER;
                    sd_dat_dir     <= 1'b1;              // start nibble on the bus
                    cnt            <= '0;
                    lo             <= 1'b0;
                    link_token_err <= 1'b0;
                    link_timed_out <= 1'b0;
                end
                sd_pkg::HEADER: if (fall) begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(8))
                        tx_req <= (op == sd_pkg::OP_WRITE);  // fetch byte 0 early
                    if (cnt == CNT_W'(9)) begin
                        cnt <= '0;
                        lo  <= (op == sd_pkg::OP_WRITE);     // byte 0 high nibble now out
                        if (op == sd_pkg::OP_WRITE) begin
                            state <= sd_pkg::TX_DATA;
                        end else begin
                            state      <= sd_pkg::WAIT_START;
                            sd_dat_dir <= 1'b0;
                        end
                    end
                end
                sd_pkg::TX_DATA: if (fall) begin
                    lo <= !lo;
                    if (lo) begin
                        cnt    <= cnt + 1'b1;
                        tx_req <= cnt != CNT_W'(sd_pkg::SECTOR_BYTES - 1);
                    end else if (cnt == CNT_W'(sd_pkg::SECTOR_BYTES)) begin
                        state      <= sd_pkg::WAIT_START;  // release for the token
                        sd_dat_dir <= 1'b0;
                    end
                end
                sd_pkg::WAIT_START: if (rise) begin
                    if (din == 4'h0)
                        state <= (op == sd_pkg::OP_WRITE) ? sd_pkg::STATUS : sd_pkg::RX_DATA;
                    else if (tmo_cnt == TMO_W'(TIMEOUT_CYCLES - 1)) begin
                        link_timed_out <= 1'b1;
                        state          <= sd_pkg::DONE;
                    end
                end
                sd_pkg::STATUS: if (rise) begin
                    link_token_err <= din != sd_pkg::TOKEN_OK;
                    state          <= sd_pkg::DONE;
                end
                sd_pkg::RX_DATA: if (rise) begin
                    lo <= !lo;
                    if (lo) begin
                        cnt      <= cnt + 1'b1;
                        rx_valid <= 1'b1;
                        if (cnt == CNT_W'(sd_pkg::SECTOR_BYTES - 1))
                            state <= sd_pkg::DONE;
                    end
                end
                default: state <= sd_pkg::IDLE;           // DONE lasts one cycle
            endcase
        end
    end

    // nibble shifting, msb first
    always_ff @(posedge CLK) begin
        if (link_start && state == sd_pkg::IDLE) begin
            dout   <= 4'h0;
            hdr_sh <= {op, sector};
        end else if (fall && tx_hi) begin
            dout  <= tx_byte[7:4];
            nib_q <= tx_byte[3:0];
        end else if (fall && state == sd_pkg::TX_DATA && lo) begin
            dout <= nib_q;
        end else if (fall && state == sd_pkg::HEADER) begin
            dout   <= hdr_sh[35:32];
            hdr_sh <= hdr_sh << 4;
        end
        if (rise && state == sd_pkg::RX_DATA) begin
            if (!lo)
                nib_q <= din;                            // high nibble first
            else
                rx_byte <= {nib_q, din};
        end
    end

endmodule

// File: rtl/sd_stream.sv
// ************************************************
// sd sector transfer engine
// moves a sector between buffer rows and link bytes
// through a 16-byte row cache
// ************************************************
`timescale 1ns/1ns

module sd_stream (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              start,
    input  sd_pkg::sd_op_t    op,
    input  sd_pkg::sector_t   sector,
    output logic              busy,
    output logic              done,
    output logic              token_err,
    output logic              timed_out,
    output sd_pkg::row_addr_t eng_row,
    output sd_pkg::row_t      eng_wdata,
    output logic              eng_we,
    input  sd_pkg::row_t      eng_rdata,
    output logic              link_start,
    input  logic              link_busy,
    input  logic              link_done,
    input  logic              link_token_err,
    input  logic              link_timed_out,
    input  logic              rx_valid,
    input  sd_pkg::byte_t     rx_byte,
    input  logic              tx_req,
    output sd_pkg::byte_t     tx_byte
);

    localparam int PTR_W = $clog2(sd_pkg::ROW_BYTES);

    logic              active;
    logic              fetch;     // row address just set up
    logic              fetch_q;   // row data arrives from buffer
    logic [PTR_W-1:0]  ptr;       // byte pointer into cache
    sd_pkg::row_addr_t row;
    sd_pkg::row_t      cache;

    assign busy      = active | link_busy;
    assign eng_row   = row;
    assign eng_wdata = cache;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            active     <= 1'b0;
            done       <= 1'b0;
            token_err  <= 1'b0;
            timed_out  <= 1'b0;
            link_start <= 1'b0;
            eng_we     <= 1'b0;
            fetch      <= 1'b0;
            fetch_q    <= 1'b0;
            ptr        <= '0;
            row        <= '0;
        end else begin
            link_start <= start;
            done       <= 1'b0;
            eng_we     <= 1'b0;
            fetch      <= 1'b0;
            fetch_q    <= fetch;
            if (start) begin
                active    <= 1'b1;
                row       <= '0;
                ptr       <= '0;
                fetch     <= (op == sd_pkg::OP_WRITE);  // preload row 0
                token_err <= 1'b0;
                timed_out <= 1'b0;
            end
            // read: flush a full cache row to the buffer
            if (eng_we)
                row <= row + 1'b1;
            if (rx_valid) begin
                ptr <= ptr + 1'b1;
                if (&ptr)
                    eng_we <= 1'b1;                     // 16th byte landed
            end
            // write: refill once the last cache byte is out
            if (tx_req) begin
                ptr <= ptr + 1'b1;
                if (&ptr) begin
                    row   <= row + 1'b1;
                    fetch <= 1'b1;
                end
            end
            if (link_done) begin
                active    <= 1'b0;
                done      <= 1'b1;
                token_err <= link_token_err;
                timed_out <= link_timed_out;
            end
        end
    end

    // cache and byte handoff
    always_ff @(posedge CLK) begin
        if (rx_valid)
            cache[ptr*8 +: 8] <= rx_byte;
        if (fetch_q)
            cache <= eng_rdata;
        if (tx_req)
            tx_byte <= cache[ptr*8 +: 8];             // ready well before next fall
    end

endmodule

// File: rtl/sd_sector_buffer.sv
// ************************************************
// sd sector buffer
// 32 x 128-bit ram, 32-bit host port, row-wide engine port
// ************************************************
`timescale 1ns/1ns

module sd_sector_buffer (
    input  logic              CLK,
    input  sd_pkg::row_addr_t host_row,
    input  logic [1:0]        host_lane,
    input  sd_pkg::wb_data_t  host_wdata,
    input  logic              host_we,
    output sd_pkg::wb_data_t  host_rdata,
    input  sd_pkg::row_addr_t eng_row,
    input  sd_pkg::row_t      eng_wdata,
    input  logic              eng_we,
    output sd_pkg::row_t      eng_rdata
);

    sd_pkg::row_t mem [32];

    always_ff @(posedge CLK) begin
        if (host_we)
            mem[host_row][host_lane*32 +: 32] <= host_wdata;  // one lane, 4 bytes
        if (eng_we)
            mem[eng_row] <= eng_wdata;                        // whole row
        host_rdata <= mem[host_row][host_lane*32 +: 32];      // registered reads
        eng_rdata  <= mem[eng_row];
    end

endmodule

// File: rtl/sd_regs.sv
// ************************************************
// sd host register block
// wishbone classic slave for control, sector, status
// and the sector buffer window
// ************************************************
`timescale 1ns/1ns

module sd_regs (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  sd_pkg::wb_addr_t  wb_adr,
    input  sd_pkg::wb_data_t  wb_dat_w,
    output sd_pkg::wb_data_t  wb_dat_r,
    output logic              wb_ack,
    output sd_pkg::row_addr_t host_row,
    output logic [1:0]        host_lane,
    output sd_pkg::wb_data_t  host_wdata,
    output logic              host_we,
    input  sd_pkg::wb_data_t  host_rdata,
    output logic              start,
    output sd_pkg::sd_op_t    op,
    output sd_pkg::sector_t   sector,
    input  logic              busy,
    input  logic              done,
    input  logic              token_err,
    input  logic              timed_out
);

    logic             req;        // new request, not yet acked
    logic             buf_sel;    // address falls in buffer window
    logic             buf_rd;     // ack cycle returns buffer data
    logic             done_q;
    logic             tok_q;
    logic             tmo_q;
    sd_pkg::wb_data_t reg_rdata;

    assign req        = wb_cyc && wb_stb && !wb_ack;  // ack drops after one cycle
    assign buf_sel    = wb_adr >= sd_pkg::BUF_BASE;
    assign host_row   = wb_adr[6:2];                  // word w -> row w/4
    assign host_lane  = wb_adr[1:0];                  //        -> lane w%4
    assign host_wdata = wb_dat_w;
    assign host_we    = req && wb_we && buf_sel;
    assign wb_dat_r   = buf_rd ? host_rdata : reg_rdata;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            wb_ack <= 1'b0;
            start  <= 1'b0;
            op     <= sd_pkg::OP_READ;
            sector <= '0;
            done_q <= 1'b0;
            tok_q  <= 1'b0;
            tmo_q  <= 1'b0;
        end else begin
            wb_ack <= req;
            start  <= 1'b0;
            // start only taken while idle, clears the old status
            if (req && wb_we && wb_adr == sd_pkg::REG_CTRL && wb_dat_w[0] && !busy) begin
                start  <= 1'b1;
                op     <= wb_dat_w[1] ? sd_pkg::OP_WRITE : sd_pkg::OP_READ;
                done_q <= 1'b0;
                tok_q  <= 1'b0;
                tmo_q  <= 1'b0;
            end
            if (req && wb_we && wb_adr == sd_pkg::REG_SECTOR && !busy)
                sector <= wb_dat_w;                   // held during an operation
            if (done) begin
                done_q <= 1'b1;
                tok_q  <= token_err;
                tmo_q  <= timed_out;
            end
        end
    end

    // read data, valid in the ack cycle
    always_ff @(posedge CLK) begin
        buf_rd <= buf_sel;
        case (wb_adr)
            sd_pkg::REG_CTRL:   reg_rdata <= {30'b0, op == sd_pkg::OP_WRITE, 1'b0};
            sd_pkg::REG_SECTOR: reg_rdata <= sector;
            sd_pkg::REG_STATUS: reg_rdata <= {28'b0, tmo_q, tok_q, done_q, busy};
            default:            reg_rdata <= '0;
        endcase
    end

endmodule

// File: rtl/sd_pkg.sv
// ************************************************
// sd host shared definitions
// widths, sector geometry, register map and enums
// ************************************************

package sd_pkg;

    typedef logic [7:0]   byte_t;      // one sector byte
    typedef logic [3:0]   nibble_t;    // one data-line beat
    typedef logic [127:0] row_t;       // 16 bytes, byte 0 in bits 7:0
    typedef logic [4:0]   row_addr_t;  // 32 rows per sector
    typedef logic [31:0]  sector_t;
    typedef logic [7:0]   wb_addr_t;   // word address
    typedef logic [31:0]  wb_data_t;

    // operation, doubles as the header's operation nibble
    typedef enum logic [3:0] {
        OP_READ  = 4'd1,
        OP_WRITE = 4'd2
    } sd_op_t;

    typedef enum logic [2:0] {
        IDLE,
        HEADER,
        TX_DATA,
        WAIT_START,
        RX_DATA,
        STATUS,
        DONE
    } link_state_t;

    localparam int      SECTOR_BYTES = 512;
    localparam int      ROW_BYTES    = 16;
    localparam nibble_t TOKEN_OK     = 4'h5;  // card accepted the write

    // ************************************************
    // register map, word addresses
    // ************************************************
    localparam wb_addr_t REG_CTRL   = 8'd0;    // bit 0 start, bit 1 write
    localparam wb_addr_t REG_SECTOR = 8'd1;
    localparam wb_addr_t REG_STATUS = 8'd2;    // busy, done, token err, timeout
    localparam wb_addr_t BUF_BASE   = 8'd128;  // buffer window, words 128..255

endpackage
